// File: Bender.yml
package:
  name: versat_mem

export_include_dirs:
  - common

sources:
  - include_dirs:
      - common
    files:
      - common/versatMemPkg.sv
      - memUnit/dualPortRam.sv
      - memUnit/memUnit.sv
      - addrGen/addrGen.sv
      - verilog/apbConfig.sv
      - verilog/versatMemTop.sv
  - target: test
    include_dirs:
      - common
    files:
      - verif/versatMem_assert.sv
      - verif/versatMemTb.sv

// File: addrGen/addrGen.sv
module addrGen (
   input  logic                  clk,
   input  logic                  rst,
   input  logic                  run,
   input  versatMemPkg::memAddrT start,
   input  versatMemPkg::memAddrT incr,
   input  versatMemPkg::memAddrT shift,
   input  versatMemPkg::cntT     iterations,
   input  versatMemPkg::cntT     period,
   input  versatMemPkg::cntT     duty,
   input  versatMemPkg::cntT     delay,
   output versatMemPkg::memAddrT addr,
   output logic                  en,
   output logic                  genDone
);
   import versatMemPkg::*;

   genStateT state;
   cntT      delayCnt;
   cntT      stepCnt;
   cntT      iterCnt;
   memAddrT  rowBase;
   memAddrT  addrR;
   logic     emptyPat;
   logic     lastStep;
   logic     lastIter;

   // nothing to emit when either loop bound is zero
   assign emptyPat = (iterations == '0) || (period == '0);
   assign lastStep = (stepCnt == period - cntT'(1));
   assign lastIter = (iterCnt == iterations - cntT'(1));

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         state    <= IDLE;
         delayCnt <= '0;
         stepCnt  <= '0;
         iterCnt  <= '0;
         rowBase  <= '0;
         addrR    <= '0;
      end else if (run) begin
         rowBase  <= start;
         addrR    <= start;
         stepCnt  <= '0;
         iterCnt  <= '0;
         delayCnt <= delay - cntT'(1);
         if (delay != '0) begin
            state <= DELAY;
         end else if (emptyPat) begin
            state <= FINISH;
         end else begin
            state <= RUN;
         end
      end else begin
         case (state)
            DELAY: begin
               if (delayCnt == '0) begin
                  state <= emptyPat ? FINISH : RUN;
               end else begin
                  delayCnt <= delayCnt - cntT'(1);
               end
            end
            RUN: begin
               if (lastStep) begin
                  stepCnt <= '0;
                  if (lastIter) begin
                     state <= FINISH;
                  end else begin
                     // next row starts one shift above the previous row
                     iterCnt <= iterCnt + cntT'(1);
                     rowBase <= rowBase + shift;
                     addrR   <= rowBase + shift;
                  end
               end else begin
                  stepCnt <= stepCnt + cntT'(1);
                  addrR   <= addrR + incr;
               end
            end
            default: begin
               state <= state;
            end
         endcase
      end
   end

   assign addr = addrR;

   // duty cycles of each period carry an access
   assign en = (state == RUN) && (stepCnt < duty);

   assign genDone = ((state == IDLE) || (state == FINISH)) && !run;

endmodule

// File: common/versatMemPkg.sv
`include "versatMem_cfg.svh"

package versatMemPkg;

   // one stream or memory word
   typedef logic [`VM_DATA_W-1:0] dataT;

   // word address into the RAM
   typedef logic [`VM_ADDR_W-1:0] memAddrT;

   // period, duty, delay and iteration counts
   typedef logic [`VM_CNT_W-1:0] cntT;

   // address generator states
   typedef enum logic [1:0] {
      IDLE,
      DELAY,
      RUN,
      FINISH
   } genStateT;

endpackage

// File: common/versatMem_cfg.svh
`ifndef VERSATMEM_CFG_SVH
`define VERSATMEM_CFG_SVH

`define VM_DATA_W 32
`define VM_ADDR_W 7
`define VM_CNT_W 10
`define VM_APB_AW 9

// APB addresses count words
// memory window when the top address bit is set
`define VM_REG_CTRL 0
`define VM_REG_STATUS 1

// port A registers, port B sits one stride above
`define VM_REG_START 8
`define VM_REG_INCR 9
`define VM_REG_SHIFT 10
`define VM_REG_ITER 11
`define VM_REG_PER 12
`define VM_REG_DUTY 13
`define VM_REG_DELAY 14
`define VM_REG_FLAGS 15
`define VM_PORT_STRIDE 8

// status bits
`define VM_STAT_DONE 0
`define VM_STAT_RUN 1

// flag bits
`define VM_FLAG_WR 0
`define VM_FLAG_EXT 1
`define VM_FLAG_REV 2

`endif

// File: memUnit/dualPortRam.sv
module dualPortRam (
   input  logic                  clk,
   input  logic                  enA,
   input  logic                  weA,
   input  versatMemPkg::memAddrT addrA,
   input  versatMemPkg::dataT    wdataA,
   output versatMemPkg::dataT    rdataA,
   input  logic                  enB,
   input  logic                  weB,
   input  versatMemPkg::memAddrT addrB,
   input  versatMemPkg::dataT    wdataB,
   output versatMemPkg::dataT    rdataB
);
   import versatMemPkg::*;

   localparam int Depth = 2 ** $bits(memAddrT);

   dataT mem [Depth];

   // both ports in one process, reads see the old word on a collision
   always_ff @(posedge clk) begin
      if (enA) begin
         if (weA) begin
            mem[addrA] <= wdataA;
         end
         rdataA <= mem[addrA];
      end
      if (enB) begin
         if (weB) begin
            mem[addrB] <= wdataB;
         end
         rdataB <= mem[addrB];
      end
   end

endmodule

// File: memUnit/memUnit.sv
module memUnit (
   input  logic                  clk,
   input  logic                  rst,
   input  logic                  run,
   input  versatMemPkg::dataT    in0,
   input  versatMemPkg::dataT    in1,
   input  versatMemPkg::memAddrT addrA,
   input  logic                  enA,
   input  logic                  genDoneA,
   input  logic                  wrEnA,
   input  logic                  extEnA,
   input  logic                  revEnA,
   input  versatMemPkg::memAddrT addrB,
   input  logic                  enB,
   input  logic                  genDoneB,
   input  logic                  wrEnB,
   input  logic                  extEnB,
   input  logic                  revEnB,
   input  logic                  hostEn,
   input  logic                  hostWe,
   input  versatMemPkg::memAddrT hostAddr,
   input  versatMemPkg::dataT    hostWdata,
   output versatMemPkg::dataT    hostRdata,
   output versatMemPkg::dataT    out0,
   output versatMemPkg::dataT    out1,
   output logic                  out0Valid,
   output logic                  out1Valid,
   output logic                  done
);
   import versatMemPkg::*;

   function automatic memAddrT revBits(input memAddrT a);
      memAddrT r;
      for (int i = 0; i < $bits(memAddrT); i++) begin
         r[i] = a[$bits(memAddrT)-1-i];
      end
      return r;
   endfunction

   // per-port views, index 0 is port A
   dataT       inD [2];
   memAddrT    genAddr [2];
   logic       genEn [2];
   logic       wrEn [2];
   logic       extEn [2];
   logic       revEn [2];
   memAddrT    selAddr [2];
   dataT       selData [2];
   logic       selEn [2];
   logic       selWe [2];
   logic       rdReq [2];
   memAddrT    addrQ [2];
   dataT       dataQ [2];
   logic       enQ [2];
   logic       weQ [2];
   dataT       rdata [2];
   dataT       outQ [2];
   logic [2:0] rdPipe [2];
   logic       hostSel;
   logic       genDoneAll;
   logic       doneArm;
   logic       doneDly;

   assign inD     = '{in0, in1};
   assign genAddr = '{addrA, addrB};
   assign genEn   = '{enA, enB};
   assign wrEn    = '{wrEnA, wrEnB};
   assign extEn   = '{extEnA, extEnB};
   assign revEn   = '{revEnA, revEnB};

   assign genDoneAll = genDoneA && genDoneB;
   assign hostSel    = hostEn && genDoneAll;

   always_comb begin
      for (int p = 0; p < 2; p++) begin
         if (extEn[p]) begin
            selAddr[p] = memAddrT'(inD[p]);
         end else begin
            selAddr[p] = revEn[p] ? revBits(genAddr[p]) : genAddr[p];
         end
         selData[p] = inD[p];
         selEn[p]   = genEn[p];
         selWe[p]   = genEn[p] && wrEn[p] && !extEn[p];
         rdReq[p]   = genEn[p] && !selWe[p];
      end
      // host borrows port A while the generators are idle
      if (hostSel) begin
         selAddr[0] = hostAddr;
         selData[0] = hostWdata;
         selEn[0]   = 1'b1;
         selWe[0]   = hostWe;
      end
   end

   always_ff @(posedge clk) begin
      addrQ <= selAddr;
      dataQ <= selData;
   end

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         for (int p = 0; p < 2; p++) begin
            enQ[p]    <= 1'b0;
            weQ[p]    <= 1'b0;
            rdPipe[p] <= '0;
            outQ[p]   <= '0;
         end
      end else begin
         for (int p = 0; p < 2; p++) begin
            enQ[p]    <= selEn[p];
            weQ[p]    <= selWe[p];
            // input reg, RAM, output reg
            rdPipe[p] <= {rdPipe[p][1:0], rdReq[p]};
            outQ[p]   <= run ? '0 : rdata[p];
         end
      end
   end

   dualPortRam u_dualPortRam (
      .clk    (clk),
      .enA    (enQ[0]),
      .weA    (weQ[0]),
      .addrA  (addrQ[0]),
      .wdataA (dataQ[0]),
      .rdataA (rdata[0]),
      .enB    (enQ[1]),
      .weB    (weQ[1]),
      .addrB  (addrQ[1]),
      .wdataB (dataQ[1]),
      .rdataB (rdata[1])
   );

   // host reads come straight from the RAM
   assign hostRdata = rdata[0];

   assign out0      = outQ[0];
   assign out1      = outQ[1];
   assign out0Valid = rdPipe[0][2];
   assign out1Valid = rdPipe[1][2];

   // two cycles behind both generators so the last read has left
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         doneArm <= 1'b0;
         doneDly <= 1'b0;
         done    <= 1'b0;
      end else begin
         if (run) begin
            doneArm <= 1'b1;
         end
         doneDly <= genDoneAll;
         done    <= doneArm && genDoneAll && doneDly;
      end
   end

endmodule

// File: verif/versatMemTb.sv
`include "versatMem_cfg.svh"

module versatMemTb;
   timeunit 1ns;
   timeprecision 1ps;
   import versatMemPkg::*;

   localparam int ClkPeriod = 20;
   localparam int Words = 2 ** `VM_ADDR_W;
   localparam int MemBase = 1 << (`VM_APB_AW - 1);
   // an APB transfer takes up to eight cycles with the idle gap
   localparam int HostCycles = (2 * Words + 2 * 2 * 8) * 8;
   localparam int StreamCycles = Words * 8 + 4 * 9 * 8 + 4 * 400;
   localparam int WatchdogCycles = 2 * (16 + HostCycles + StreamCycles);

   logic                  clk;
   logic                  rst;
   logic                  PSEL;
   logic                  PENABLE;
   logic                  PWRITE;
   logic [`VM_APB_AW-1:0] PADDR;
   dataT                  PWDATA;
   dataT                  PRDATA;
   logic                  PREADY;
   logic                  PSLVERR;
   dataT                  in0;
   dataT                  in1;
   dataT                  out0;
   dataT                  out1;
   logic                  out0Valid;
   logic                  out1Valid;
   logic                  done;
   logic                  running;

   int   seed = 19665;
   int   errors = 0;
   int   testsFailed = 0;
   int   lastWaits;
   int   cycleCnt = 0;
   int   acceptCycle;
   int   runCycle;
   int   firstValid1;
   logic doneAfterReset;
   dataT refMem [Words];
   dataT got0 [$];
   dataT got1 [$];
   dataT expQ [$];

   versatMemTop u_versatMemTop (.*);

   initial clk = 1'b0;
   always #(ClkPeriod / 2) clk = ~clk;

   // cycle number, read only at the falling edge
   always @(posedge clk) begin
      cycleCnt++;
   end

   // stream outputs are taken in the middle of the cycle
   always @(negedge clk) begin
      if (out0Valid) begin
         got0.push_back(out0);
      end
      if (out1Valid) begin
         if (got1.size() == 0) begin
            firstValid1 = cycleCnt;
         end
         got1.push_back(out1);
      end
   end

   initial begin
      #(WatchdogCycles * ClkPeriod);
      $display("watchdog expired before the tests finished");
      $display("Result: FAILED");
      $finish;
   end

   task automatic reportMismatch(input string name, input dataT got, input dataT exp);
      $display("Error: %s got %h expected %h", name, got, exp);
      errors++;
   endtask

   task automatic reportFailure(input string what);
      $display("%s", what);
      errors++;
   endtask

   task automatic apbXfer(input logic wr, input int addr, input dataT wdata,
                          output dataT rdata, output logic err);
      @(posedge clk);
      #2;
      PSEL    = 1'b1;
      PENABLE = 1'b0;
      PWRITE  = wr;
      PADDR   = addr[`VM_APB_AW-1:0];
      PWDATA  = wdata;
      @(posedge clk);
      #2;
      PENABLE   = 1'b1;
      lastWaits = 0;
      @(negedge clk);
      while (!PREADY && lastWaits < 8) begin
         lastWaits++;
         @(negedge clk);
      end
      if (!PREADY) begin
         reportFailure($sformatf("APB transfer at address %0h never got PREADY", addr));
      end
      acceptCycle = cycleCnt;
      rdata = PRDATA;
      err   = PSLVERR;
      @(posedge clk);
      #2;
      PSEL    = 1'b0;
      PENABLE = 1'b0;
   endtask

   task automatic apbWrite(input int addr, input dataT data, output logic err);
      dataT unused;
      apbXfer(1'b1, addr, data, unused, err);
   endtask

   task automatic apbRead(input int addr, output dataT data, output logic err);
      apbXfer(1'b0, addr, '0, data, err);
   endtask

   function automatic int regAddr(input int port, input int r);
      return r + port * `VM_PORT_STRIDE;
   endfunction

   function automatic int patternAddr(input int start, input int incr, input int shift,
                                      input int i, input int p);
      return (start + i * shift + p * incr) % Words;
   endfunction

   function automatic int reverseAddr(input int a);
      int r;
      r = 0;
      for (int b = 0; b < `VM_ADDR_W; b++) begin
         if (a[b]) begin
            r |= 1 << (`VM_ADDR_W - 1 - b);
         end
      end
      return r;
   endfunction

   task automatic configPort(input int port, input int start, input int incr, input int shift,
                             input int iters, input int per, input int duty, input int delay,
                             input int flags);
      int   vals [8];
      logic err;
      vals = '{start, incr, shift, iters, per, duty, delay, flags};
      for (int r = 0; r < 8; r++) begin
         apbWrite(regAddr(port, `VM_REG_START + r), dataT'(vals[r]), err);
         if (err) begin
            reportFailure("configuration write was refused while idle");
         end
      end
   endtask

   task automatic startRun;
      logic err;
      int   n;
      got0.delete();
      got1.delete();
      firstValid1 = -1;
      apbWrite(`VM_REG_CTRL, 32'h1, err);
      runCycle = acceptCycle;
      n = 0;
      while (done && n < 10) begin
         @(negedge clk);
         n++;
      end
      if (done) begin
         reportFailure("done did not fall after the run was started");
      end
   endtask

   task automatic waitDone(input int limit);
      int n;
      n = 0;
      while (!done && n < limit) begin
         @(negedge clk);
         n++;
      end
      if (!done) begin
         reportFailure($sformatf("done did not rise within %0d cycles", limit));
      end
   endtask

   task automatic checkMemory;
      dataT rd;
      logic err;
      for (int a = 0; a < Words; a++) begin
         apbRead(MemBase + a, rd, err);
         if (err) begin
            reportFailure("memory read was refused while idle");
         end
         if (lastWaits != 2) begin
            reportMismatch("PREADY wait cycles", lastWaits, 2);
         end
         if (rd !== refMem[a]) begin
            reportMismatch($sformatf("PRDATA[%0h]", a), rd, refMem[a]);
         end
      end
   endtask

   task automatic buildExpected(input int start, input int incr, input int shift,
                                input int iters, input int per, input int duty, input logic rev);
      int a;
      expQ.delete();
      for (int i = 0; i < iters; i++) begin
         for (int p = 0; p < per; p++) begin
            a = patternAddr(start, incr, shift, i, p);
            if (p < duty) begin
               expQ.push_back(refMem[rev ? reverseAddr(a) : a]);
            end
         end
      end
   endtask

   task automatic compareStream(input string name, input int port);
      dataT got [$];
      if (port == 0) begin
         got = got0;
      end else begin
         got = got1;
      end
      if (got.size() != expQ.size()) begin
         reportMismatch({name, " count"}, got.size(), expQ.size());
      end
      for (int k = 0; k < got.size() && k < expQ.size(); k++) begin
         if (got[k] !== expQ[k]) begin
            reportMismatch($sformatf("%s[%0d]", name, k), got[k], expQ[k]);
         end
      end
   endtask

   task automatic finishTest(input string name, input int base);
      $display("%s finished with %0d errors", name, errors - base);
      if (errors > base) begin
         testsFailed++;
      end
   endtask

   task automatic hostAccess;
      int   base;
      dataT val;
      dataT mask;
      dataT rd;
      logic err;
      base = errors;
      for (int p = 0; p < 2; p++) begin
         for (int r = 0; r < 8; r++) begin
            val  = $random(seed);
            // start, incr and shift are addresses, the next four are counts
            mask = (r < 3) ? dataT'((1 << `VM_ADDR_W) - 1) :
                   (r < 7) ? dataT'((1 << `VM_CNT_W) - 1) : dataT'(7);
            apbWrite(regAddr(p, `VM_REG_START + r), val, err);
            if (err || lastWaits != 0) begin
               reportFailure("configuration write did not finish in the first cycle");
            end
            apbRead(regAddr(p, `VM_REG_START + r), rd, err);
            if (err || lastWaits != 0) begin
               reportFailure("configuration read did not finish in the first cycle");
            end
            if (rd !== (val & mask)) begin
               reportMismatch("PRDATA", rd, val & mask);
            end
         end
      end
      for (int a = 0; a < Words; a++) begin
         refMem[a] = $random(seed);
         apbWrite(MemBase + a, refMem[a], err);
         if (err) begin
            reportFailure("memory write was refused while idle");
         end
         if (lastWaits != 1) begin
            reportMismatch("PREADY wait cycles", lastWaits, 1);
         end
      end
      checkMemory();
      finishTest("hostAccess", base);
   endtask

   task automatic streamWrite;
      int   base;
      dataT val;
      base = errors;
      val  = $random(seed);
      @(posedge clk);
      #2;
      in0 = val;
      configPort(0, 90, 3, 17, 4, 6, 4, 2, 1 << `VM_FLAG_WR);
      configPort(1, 0, 0, 0, 0, 0, 0, 0, 0);
      startRun();
      waitDone(200);
      for (int i = 0; i < 4; i++) begin
         for (int p = 0; p < 4; p++) begin
            refMem[patternAddr(90, 3, 17, i, p)] = val;
         end
      end
      if (got0.size() != 0 || got1.size() != 0) begin
         reportFailure("a valid strobe appeared during a write-only run");
      end
      checkMemory();
      finishTest("streamWrite", base);
   endtask

   task automatic streamRead;
      int base;
      int latency;
      base = errors;
      configPort(0, 0, 0, 0, 0, 0, 0, 0, 0);
      configPort(1, 100, 5, 9, 3, 5, 3, 4, 0);
      buildExpected(100, 5, 9, 3, 5, 3, 1'b0);
      startRun();
      waitDone(200);
      compareStream("out1", 1);
      // run pulse, delay plus one to the first address, three to the output
      latency = 1 + (4 + 1) + 3;
      if (firstValid1 - runCycle != latency) begin
         reportMismatch("out1Valid latency", firstValid1 - runCycle, latency);
      end
      finishTest("streamRead", base);
   endtask

   task automatic bothPorts;
      int   base;
      int   extAddr;
      dataT rd;
      logic err;
      base = errors;
      @(posedge clk);
      #2;
      in1     = $random(seed);
      extAddr = in1 % Words;
      configPort(0, 3, 7, 1, 2, 4, 3, 0, 1 << `VM_FLAG_REV);
      // write flag set too, external addressing must still only read
      configPort(1, 0, 1, 0, 3, 2, 2, 1, (1 << `VM_FLAG_EXT) | (1 << `VM_FLAG_WR));
      startRun();
      waitDone(200);
      buildExpected(3, 7, 1, 2, 4, 3, 1'b1);
      compareStream("out0", 0);
      expQ.delete();
      repeat (6) expQ.push_back(refMem[extAddr]);
      compareStream("out1", 1);
      apbRead(MemBase + extAddr, rd, err);
      if (rd !== refMem[extAddr]) begin
         reportMismatch("PRDATA", rd, refMem[extAddr]);
      end
      finishTest("bothPorts", base);
   endtask

   task automatic runControl;
      int   base;
      dataT rd;
      logic err;
      base = errors;
      if (doneAfterReset !== 1'b0) begin
         reportFailure("done was not low after reset");
      end
      configPort(0, 0, 1, 0, 20, 10, 10, 0, 0);
      configPort(1, 0, 0, 0, 0, 0, 0, 0, 0);
      startRun();
      if (running !== 1'b1) begin
         reportMismatch("running", running, 1);
      end
      apbWrite(regAddr(0, `VM_REG_START), 32'h55, err);
      if (!err) begin
         reportFailure("configuration write while running was not refused");
      end
      apbWrite(MemBase + 9, ~refMem[9], err);
      if (!err) begin
         reportFailure("memory write while running was not refused");
      end
      apbRead(MemBase + 9, rd, err);
      if (!err) begin
         reportFailure("memory read while running was not refused");
      end
      apbRead(`VM_REG_STATUS, rd, err);
      if (rd !== 32'h2) begin
         reportMismatch("PRDATA", rd, 32'h2);
      end
      waitDone(400);
      if (running !== 1'b0) begin
         reportMismatch("running", running, 0);
      end
      apbRead(regAddr(0, `VM_REG_START), rd, err);
      if (rd !== 32'h0) begin
         reportMismatch("PRDATA", rd, 32'h0);
      end
      apbRead(`VM_REG_STATUS, rd, err);
      if (rd !== 32'h1) begin
         reportMismatch("PRDATA", rd, 32'h1);
      end
      apbRead(MemBase + 9, rd, err);
      if (rd !== refMem[9]) begin
         reportMismatch("PRDATA", rd, refMem[9]);
      end
      finishTest("runControl", base);
   endtask

   initial begin
      rst     = 1'b1;
      PSEL    = 1'b0;
      PENABLE = 1'b0;
      PWRITE  = 1'b0;
      PADDR   = '0;
      PWDATA  = '0;
      in0     = '0;
      in1     = '0;
      repeat (16) @(posedge clk);
      #2;
      rst = 1'b0;
      @(negedge clk);
      doneAfterReset = done;
      hostAccess();
      streamWrite();
      streamRead();
      bothPorts();
      runControl();
      errors += u_versatMemTop.u_versatMemAssert.failCount;
      $display("tests run 5, tests failed %0d, errors %0d", testsFailed, errors);
      if (errors == 0) begin
         $display("Result: PASSED");
      end else begin
         $display("Result: FAILED");
      end
      $finish;
   end

endmodule

// File: verif/versatMem_assert.sv
module versatMemAssert (
   input logic clk,
   input logic rst,
   input logic PSEL,
   input logic PENABLE,
   input logic PREADY,
   input logic PSLVERR,
   input logic done,
   input logic running,
   input logic out0Valid,
   input logic out1Valid
);
   timeunit 1ns;
   timeprecision 1ps;

   int         failCount = 0;
   logic [2:0] runHist;
   logic       seenRun;

   // running over the last three cycles covers the pipeline drain
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         runHist <= '0;
         seenRun <= 1'b0;
      end else begin
         runHist <= {runHist[1:0], running};
         if (running) begin
            seenRun <= 1'b1;
         end
      end
   end

   // at most two wait states on any access
   accessCompletes: assert property (@(posedge clk) disable iff (rst)
      PSEL && PENABLE |-> ##[0:2] PREADY)
      else begin
         failCount++;
         $error("APB access not completed within two wait states");
      end

   // after the first run exactly one of done and running is high
   doneNotRunning: assert property (@(posedge clk) disable iff (rst)
      seenRun |-> (done != running))
      else begin
         failCount++;
         $error("done and running not exclusive");
      end

   validWhileActive: assert property (@(posedge clk) disable iff (rst)
      (out0Valid || out1Valid) |-> running || (runHist != '0))
      else begin
         failCount++;
         $error("valid strobe outside a run and its drain");
      end

   // refused accesses end in their first access cycle
   errWithReady: assert property (@(posedge clk) disable iff (rst)
      PSLVERR |-> PREADY && !$past(PENABLE))
      else begin
         failCount++;
         $error("PSLVERR outside the first cycle of a completing access");
      end

endmodule

bind versatMemTop versatMemAssert u_versatMemAssert (
   .clk       (clk),
   .rst       (rst),
   .PSEL      (PSEL),
   .PENABLE   (PENABLE),
   .PREADY    (PREADY),
   .PSLVERR   (PSLVERR),
   .done      (done),
   .running   (running),
   .out0Valid (out0Valid),
   .out1Valid (out1Valid)
);

// File: verilog.f
+incdir+common
common/versatMemPkg.sv
memUnit/dualPortRam.sv
memUnit/memUnit.sv
addrGen/addrGen.sv
verilog/apbConfig.sv
verilog/versatMemTop.sv
verif/versatMem_assert.sv
verif/versatMemTb.sv

// File: verilog/apbConfig.sv
`include "versatMem_cfg.svh"

module apbConfig (
   input  logic                  clk,
   input  logic                  rst,
   input  logic                  PSEL,
   input  logic                  PENABLE,
   input  logic                  PWRITE,
   input  logic [`VM_APB_AW-1:0] PADDR,
   input  versatMemPkg::dataT    PWDATA,
   output versatMemPkg::dataT    PRDATA,
   output logic                  PREADY,
   output logic                  PSLVERR,
   input  logic                  done,
   output versatMemPkg::memAddrT startA,
   output versatMemPkg::memAddrT incrA,
   output versatMemPkg::memAddrT shiftA,
   output versatMemPkg::cntT     iterationsA,
   output versatMemPkg::cntT     periodA,
   output versatMemPkg::cntT     dutyA,
   output versatMemPkg::cntT     delayA,
   output logic                  wrEnA,
   output logic                  extEnA,
   output logic                  revEnA,
   output versatMemPkg::memAddrT startB,
   output versatMemPkg::memAddrT incrB,
   output versatMemPkg::memAddrT shiftB,
   output versatMemPkg::cntT     iterationsB,
   output versatMemPkg::cntT     periodB,
   output versatMemPkg::cntT     dutyB,
   output versatMemPkg::cntT     delayB,
   output logic                  wrEnB,
   output logic                  extEnB,
   output logic                  revEnB,
   output logic                  run,
   output logic                  running,
   output logic                  hostEn,
   output logic                  hostWe,
   output versatMemPkg::memAddrT hostAddr,
   output versatMemPkg::dataT    hostWdata,
   input  versatMemPkg::dataT    hostRdata
);
   import versatMemPkg::*;

   memAddrT    startR [2];
   memAddrT    incrR [2];
   memAddrT    shiftR [2];
   cntT        iterR [2];
   cntT        perR [2];
   cntT        dutyR [2];
   cntT        delayR [2];
   logic [2:0] flagsR [2];
   logic [1:0] waitCnt;
   logic       runningR;
   logic       access;
   logic       memWin;
   logic       busy;
   logic       refuse;
   logic       memReady;
   logic       cfgWr;
   int         regIdx;

   assign access = PSEL && PENABLE;
   assign memWin = PADDR[`VM_APB_AW-1];
   assign regIdx = int'(PADDR);
   assign busy   = running || run;
   // config and status reads stay open while running
   assign refuse = busy && (PWRITE || memWin);

   // window writes wait one cycle, reads two for input reg and RAM
   assign memReady = (waitCnt == (PWRITE ? 2'd1 : 2'd2));
   assign PREADY   = access && (refuse || !memWin || memReady);
   assign PSLVERR  = access && refuse;
   assign cfgWr    = access && PWRITE && !memWin && !busy;

   assign hostEn    = access && memWin && !refuse && (waitCnt == 2'd0);
   assign hostWe    = PWRITE;
   assign hostAddr  = memAddrT'(PADDR);
   assign hostWdata = PWDATA;

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         waitCnt  <= '0;
         run      <= 1'b0;
         runningR <= 1'b0;
      end else begin
         if (access && memWin && !refuse && !memReady) begin
            waitCnt <= waitCnt + 2'd1;
         end else begin
            waitCnt <= '0;
         end
         run <= cfgWr && (regIdx == `VM_REG_CTRL) && PWDATA[0];
         if (run) begin
            runningR <= 1'b1;
         end else if (done) begin
            runningR <= 1'b0;
         end
      end
   end

   // drops in the same cycle that done rises
   assign running = runningR && !done;

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         for (int p = 0; p < 2; p++) begin
            startR[p] <= '0;
            incrR[p]  <= '0;
            shiftR[p] <= '0;
            iterR[p]  <= '0;
            perR[p]   <= '0;
            dutyR[p]  <= '0;
            delayR[p] <= '0;
            flagsR[p] <= '0;
         end
      end else if (cfgWr) begin
         for (int p = 0; p < 2; p++) begin
            case (regIdx - p * `VM_PORT_STRIDE)
               `VM_REG_START: startR[p] <= memAddrT'(PWDATA);
               `VM_REG_INCR:  incrR[p]  <= memAddrT'(PWDATA);
               `VM_REG_SHIFT: shiftR[p] <= memAddrT'(PWDATA);
               `VM_REG_ITER:  iterR[p]  <= cntT'(PWDATA);
               `VM_REG_PER:   perR[p]   <= cntT'(PWDATA);
               `VM_REG_DUTY:  dutyR[p]  <= cntT'(PWDATA);
               `VM_REG_DELAY: delayR[p] <= cntT'(PWDATA);
               `VM_REG_FLAGS: flagsR[p] <= PWDATA[2:0];
               default:       flagsR[p] <= flagsR[p];
            endcase
         end
      end
   end

   always_comb begin
      PRDATA = '0;
      if (memWin) begin
         PRDATA = hostRdata;
      end else if (regIdx == `VM_REG_STATUS) begin
         PRDATA[`VM_STAT_DONE] = done;
         PRDATA[`VM_STAT_RUN]  = running;
      end else begin
         for (int p = 0; p < 2; p++) begin
            case (regIdx - p * `VM_PORT_STRIDE)
               `VM_REG_START: PRDATA = dataT'(startR[p]);
               `VM_REG_INCR:  PRDATA = dataT'(incrR[p]);
               `VM_REG_SHIFT: PRDATA = dataT'(shiftR[p]);
               `VM_REG_ITER:  PRDATA = dataT'(iterR[p]);
               `VM_REG_PER:   PRDATA = dataT'(perR[p]);
               `VM_REG_DUTY:  PRDATA = dataT'(dutyR[p]);
               `VM_REG_DELAY: PRDATA = dataT'(delayR[p]);
               `VM_REG_FLAGS: PRDATA = dataT'(flagsR[p]);
               default:       PRDATA = PRDATA;
            endcase
         end
      end
   end

   assign startA      = startR[0];
   assign incrA       = incrR[0];
   assign shiftA      = shiftR[0];
   assign iterationsA = iterR[0];
   assign periodA     = perR[0];
   assign dutyA       = dutyR[0];
   assign delayA      = delayR[0];
   assign wrEnA       = flagsR[0][`VM_FLAG_WR];
   assign extEnA      = flagsR[0][`VM_FLAG_EXT];
   assign revEnA      = flagsR[0][`VM_FLAG_REV];
   assign startB      = startR[1];
   assign incrB       = incrR[1];
   assign shiftB      = shiftR[1];
   assign iterationsB = iterR[1];
   assign periodB     = perR[1];
   assign dutyB       = dutyR[1];
   assign delayB      = delayR[1];
   assign wrEnB       = flagsR[1][`VM_FLAG_WR];
   assign extEnB      = flagsR[1][`VM_FLAG_EXT];
   assign revEnB      = flagsR[1][`VM_FLAG_REV];

endmodule

// File: verilog/versatMemTop.sv
`include "versatMem_cfg.svh"

module versatMemTop (
   input  logic                  clk,
   input  logic                  rst,
   input  logic                  PSEL,
   input  logic                  PENABLE,
   input  logic                  PWRITE,
   input  logic [`VM_APB_AW-1:0] PADDR,
   input  versatMemPkg::dataT    PWDATA,
   output versatMemPkg::dataT    PRDATA,
   output logic                  PREADY,
   output logic                  PSLVERR,
   input  versatMemPkg::dataT    in0,
   input  versatMemPkg::dataT    in1,
   output versatMemPkg::dataT    out0,
   output versatMemPkg::dataT    out1,
   output logic                  out0Valid,
   output logic                  out1Valid,
   output logic                  done,
   output logic                  running
);
   import versatMemPkg::*;

   // per-port configuration
   memAddrT startA, incrA, shiftA;
   memAddrT startB, incrB, shiftB;
   cntT     iterationsA, periodA, dutyA, delayA;
   cntT     iterationsB, periodB, dutyB, delayB;
   logic    wrEnA, extEnA, revEnA;
   logic    wrEnB, extEnB, revEnB;

   logic    run;
   logic    hostEn;
   logic    hostWe;
   memAddrT hostAddr;
   dataT    hostWdata;
   dataT    hostRdata;

   // generator outputs
   memAddrT addrA, addrB;
   logic    enA, enB;
   logic    genDoneA, genDoneB;

   apbConfig u_apbConfig (.*);

   addrGen u_addrGenA (
      .clk        (clk),
      .rst        (rst),
      .run        (run),
      .start      (startA),
      .incr       (incrA),
      .shift      (shiftA),
      .iterations (iterationsA),
      .period     (periodA),
      .duty       (dutyA),
      .delay      (delayA),
      .addr       (addrA),
      .en         (enA),
      .genDone    (genDoneA)
   );

   addrGen u_addrGenB (
      .clk        (clk),
      .rst        (rst),
      .run        (run),
      .start      (startB),
      .incr       (incrB),
      .shift      (shiftB),
      .iterations (iterationsB),
      .period     (periodB),
      .duty       (dutyB),
      .delay      (delayB),
      .addr       (addrB),
      .en         (enB),
      .genDone    (genDoneB)
   );

   memUnit u_memUnit (.*);

endmodule
